// File: logic/div_pkg.sv
// ####################################################################
// Shared widths and encodings of the 32-bit iterative divider
// signed_mode bit 0 marks operand A as signed, bit 1 marks operand B
// ####################################################################

package div_pkg;

  // Operand and result width
  localparam int unsigned DATA_W = 32;

  // Bit index of the long division
  localparam int unsigned CNT_W = 5;

  // First quotient bit handled in the compare phase
  localparam logic [CNT_W-1:0] CNT_START = CNT_W'(31);

  // Quotient or remainder
  typedef enum logic {
    OP_DIV = 1'b0,
    OP_REM = 1'b1
  } div_op_e;

  // Sequencer states, in the order they are visited
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,
    ST_ABS_A       = 3'd1,
    ST_ABS_B       = 3'd2,
    ST_COMP        = 3'd3,
    ST_LAST        = 3'd4,
    ST_CHANGE_SIGN = 3'd5,
    ST_FINISH      = 3'd6
  } div_state_e;

endpackage

// File: logic/div_ctrl_fsm.sv
// ####################################################################
// Sequencer of the restoring divider
// Inputs must stay stable while div_en_i is high; a low enable freezes
// the sequence, and ST_FINISH waits for ready_i before leaving
// ####################################################################

`timescale 1ns/1ps

module div_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   div_en_i,
  input  logic                   ready_i,
  input  logic                   data_ind_timing_i,
  input  logic                   b_zero_i,
  input  logic                   last_i,
  output logic                   step_o,
  output logic                   valid_o,
  output div_pkg::div_state_e    state_o
);

  div_pkg::div_state_e state_q;
  div_pkg::div_state_e state_d;
  logic                hold;
  logic                early_finish;

  // Division by zero skips the iterations unless timing must not leak data
  assign early_finish = b_zero_i & ~data_ind_timing_i;

  // Result is held until the consumer accepts it
  assign hold    = (state_q == div_pkg::ST_FINISH) & ~ready_i;
  assign valid_o = (state_q == div_pkg::ST_FINISH);
  assign step_o  = div_en_i & ~hold;

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      div_pkg::ST_IDLE: begin
        if (early_finish) begin
          state_d = div_pkg::ST_FINISH;
        end else begin
          state_d = div_pkg::ST_ABS_A;
        end
      end

      div_pkg::ST_ABS_A: begin
        state_d = div_pkg::ST_ABS_B;
      end

      div_pkg::ST_ABS_B: begin
        state_d = div_pkg::ST_COMP;
      end

      // One quotient bit per cycle until the counter reaches its last step
      div_pkg::ST_COMP: begin
        if (last_i) begin
          state_d = div_pkg::ST_LAST;
        end
      end

      div_pkg::ST_LAST: begin
        state_d = div_pkg::ST_CHANGE_SIGN;
      end

      div_pkg::ST_CHANGE_SIGN: begin
        state_d = div_pkg::ST_FINISH;
      end

      // Only reached with ready_i high, since step is low otherwise
      div_pkg::ST_FINISH: begin
        state_d = div_pkg::ST_IDLE;
      end

      default: begin
        state_d = div_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= div_pkg::ST_IDLE;
    end else if (step_o) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

// File: logic/div_bit_counter.sv
// ####################################################################
// Bit index of the long division, counting down through ST_COMP
// last_o flags the final compare step (count of 1)
// ####################################################################

`timescale 1ns/1ps

module div_bit_counter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          step_i,
  input  div_pkg::div_state_e           state_i,
  output logic [div_pkg::CNT_W-1:0]     bit_idx_o,
  output logic                          last_o
);

  logic [div_pkg::CNT_W-1:0] cnt_q;
  logic [div_pkg::CNT_W-1:0] cnt_d;

  // Reload outside the compare phase so every division starts at bit 31
  always_comb begin
    if (state_i == div_pkg::ST_COMP) begin
      cnt_d = cnt_q - div_pkg::CNT_W'(1);
    end else begin
      cnt_d = div_pkg::CNT_START;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= div_pkg::CNT_START;
    end else if (step_i) begin
      cnt_q <= cnt_d;
    end
  end

  assign bit_idx_o = cnt_q;
  assign last_o    = (cnt_q == div_pkg::CNT_W'(1));

endmodule

// File: logic/div_datapath.sv
// ####################################################################
// Restoring long division datapath with one shared 33-bit adder
// Operands are read every cycle and must stay stable for the whole op
// Registers only advance on step_i
// ####################################################################

`timescale 1ns/1ps

module div_datapath (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          step_i,
  input  div_pkg::div_state_e           state_i,
  input  logic [div_pkg::CNT_W-1:0]     bit_idx_i,
  input  div_pkg::div_op_e              operator_i,
  input  logic [1:0]                    signed_mode_i,
  input  logic [div_pkg::DATA_W-1:0]    op_a_i,
  input  logic [div_pkg::DATA_W-1:0]    op_b_i,
  output logic                          b_zero_o,
  output logic [div_pkg::DATA_W-1:0]    result_o
);

  localparam int unsigned W = div_pkg::DATA_W;

  // Shared adder, computes a - b with both operands extended by a low one
  logic [W:0]   adder_a;
  logic [W:0]   adder_b;
  logic [W:0]   adder_sum;
  logic [W-1:0] adder_res;

  logic [W-1:0] remainder_q;
  logic [W-1:0] remainder_d;
  logic [W-1:0] numerator_q;
  logic [W-1:0] numerator_d;
  logic [W-1:0] denominator_q;
  logic [W-1:0] denominator_d;
  logic [W-1:0] quotient_q;
  logic [W-1:0] quotient_d;
  logic         by_zero_q;
  logic         by_zero_d;

  logic                      sign_a;
  logic                      sign_b;
  logic                      div_change_sign;
  logic                      rem_change_sign;
  logic                      is_greater_equal;
  logic [W-1:0]              one_shift;
  logic [W-1:0]              next_remainder;
  logic [W-1:0]              next_quotient;
  logic [div_pkg::CNT_W-1:0] num_bit_idx;

  assign b_zero_o = (op_b_i == '0);

  assign sign_a = signed_mode_i[0] & op_a_i[W-1];
  assign sign_b = signed_mode_i[1] & op_b_i[W-1];

  // A zero divisor keeps the all-ones quotient unsigned
  assign div_change_sign = (sign_a ^ sign_b) & ~by_zero_q;
  assign rem_change_sign = sign_a;

  // {a,1} + {~b,1} equals twice (a - b), so the difference sits in the upper bits
  assign adder_sum = adder_a + adder_b;
  assign adder_res = adder_sum[W:1];

  // Same-sign operands compare by the difference, otherwise by the remainder MSB
  always_comb begin
    if ((remainder_q[W-1] ^ denominator_q[W-1]) == 1'b0) begin
      is_greater_equal = ~adder_res[W-1];
    end else begin
      is_greater_equal = remainder_q[W-1];
    end
  end

  assign one_shift      = {{(W-1){1'b0}}, 1'b1} << bit_idx_i;
  assign next_remainder = is_greater_equal ? adder_res : remainder_q;
  assign next_quotient  = is_greater_equal ? (quotient_q | one_shift) : quotient_q;

  // Numerator bit brought down into the remainder on this step
  assign num_bit_idx = bit_idx_i - div_pkg::CNT_W'(1);

  always_comb begin
    adder_a       = {{W{1'b0}}, 1'b1};
    adder_b       = {~op_b_i, 1'b1};
    remainder_d   = remainder_q;
    numerator_d   = numerator_q;
    denominator_d = denominator_q;
    quotient_d    = quotient_q;
    by_zero_d     = by_zero_q;

    unique case (state_i)
      // Preset the result a zero divisor would give
      div_pkg::ST_IDLE: begin
        if (operator_i == div_pkg::OP_DIV) begin
          remainder_d = '1;
        end else begin
          remainder_d = op_a_i;
        end
        by_zero_d = b_zero_o;
      end

      // |A| = 0 - A
      div_pkg::ST_ABS_A: begin
        adder_b     = {~op_a_i, 1'b1};
        quotient_d  = '0;
        numerator_d = sign_a ? adder_res : op_a_i;
      end

      // |B| = 0 - B, and the numerator MSB seeds the remainder
      div_pkg::ST_ABS_B: begin
        adder_b       = {~op_b_i, 1'b1};
        remainder_d   = {{(W-1){1'b0}}, numerator_q[W-1]};
        denominator_d = sign_b ? adder_res : op_b_i;
      end

      div_pkg::ST_COMP: begin
        adder_a     = {remainder_q, 1'b1};
        adder_b     = {~denominator_q, 1'b1};
        remainder_d = {next_remainder[W-2:0], numerator_q[num_bit_idx]};
        quotient_d  = next_quotient;
      end

      // Final bit, keep only the value the operator asks for
      div_pkg::ST_LAST: begin
        adder_a = {remainder_q, 1'b1};
        adder_b = {~denominator_q, 1'b1};
        if (operator_i == div_pkg::OP_DIV) begin
          remainder_d = next_quotient;
        end else begin
          remainder_d = next_remainder;
        end
      end

      // Negate the result when the signs call for it
      div_pkg::ST_CHANGE_SIGN: begin
        adder_b = {~remainder_q, 1'b1};
        if (operator_i == div_pkg::OP_DIV) begin
          remainder_d = div_change_sign ? adder_res : remainder_q;
        end else begin
          remainder_d = rem_change_sign ? adder_res : remainder_q;
        end
      end

      default: begin
        remainder_d = remainder_q;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (step_i) begin
      remainder_q   <= remainder_d;
      numerator_q   <= numerator_d;
      denominator_q <= denominator_d;
      quotient_q    <= quotient_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      by_zero_q <= 1'b0;
    end else if (step_i) begin
      by_zero_q <= by_zero_d;
    end
  end

  // The remainder register carries the final result in ST_FINISH
  assign result_o = remainder_q;

endmodule

// File: logic/div_unit.sv
// ####################################################################
// 32-bit iterative divider for signed and unsigned DIV and REM
// Hold div_en_i and the operands stable until valid_o is accepted
// 36 enabled cycles per op, 1 on a zero divisor without const timing
// ####################################################################

`timescale 1ns/1ps

module div_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          div_en_i,
  input  div_pkg::div_op_e              operator_i,
  input  logic [1:0]                    signed_mode_i,
  input  logic [div_pkg::DATA_W-1:0]    op_a_i,
  input  logic [div_pkg::DATA_W-1:0]    op_b_i,
  input  logic                          data_ind_timing_i,
  input  logic                          ready_i,
  output logic [div_pkg::DATA_W-1:0]    result_o,
  output logic                          valid_o
);

  logic                      step;
  logic                      last;
  logic                      b_zero;
  logic [div_pkg::CNT_W-1:0] bit_idx;
  div_pkg::div_state_e       state_q;

  div_ctrl_fsm div_ctrl_fsm_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .div_en_i          (div_en_i),
    .ready_i           (ready_i),
    .data_ind_timing_i (data_ind_timing_i),
    .b_zero_i          (b_zero),
    .last_i            (last),
    .step_o            (step),
    .valid_o           (valid_o),
    .state_o           (state_q)
  );

  div_bit_counter div_bit_counter_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .step_i    (step),
    .state_i   (state_q),
    .bit_idx_o (bit_idx),
    .last_o    (last)
  );

  div_datapath div_datapath_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .step_i        (step),
    .state_i       (state_q),
    .bit_idx_i     (bit_idx),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .b_zero_o      (b_zero),
    .result_o      (result_o)
  );

endmodule

// File: tests/div_unit_checker.sv
// ####################################################################
// Bound checks of the divider: result value, latency, back-pressure hold
// Expected values come from a 34-bit signed model of the DIV/REM rules
// An op starts on the first enabled edge while no op is pending
// ####################################################################

`timescale 1ns/1ps

module div_unit_checker (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          div_en_i,
  input div_pkg::div_op_e              operator_i,
  input logic [1:0]                    signed_mode_i,
  input logic [div_pkg::DATA_W-1:0]    op_a_i,
  input logic [div_pkg::DATA_W-1:0]    op_b_i,
  input logic                          data_ind_timing_i,
  input logic                          ready_i,
  input logic [div_pkg::DATA_W-1:0]    result_o,
  input logic                          valid_o
);

  int unsigned                fail_cnt = 0;
  logic                       busy;
  logic [div_pkg::DATA_W-1:0] exp_res;
  int unsigned                cyc_cnt;
  int unsigned                exp_cyc;

  // Operands widened so that the most negative value and full unsigned range both fit
  function automatic logic [31:0] model_result(input logic op_rem, input logic [1:0] mode,
                                               input logic [31:0] a, input logic [31:0] b);
    logic signed [33:0] a_x;
    logic signed [33:0] b_x;
    logic signed [33:0] q_x;
    logic signed [33:0] r_x;
    a_x = {{2{mode[0] & a[31]}}, a};
    b_x = {{2{mode[1] & b[31]}}, b};
    if (b == '0) begin
      return op_rem ? a : '1;
    end
    q_x = a_x / b_x;
    r_x = a_x % b_x;
    return op_rem ? r_x[31:0] : q_x[31:0];
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy    <= 1'b0;
      cyc_cnt <= 0;
      exp_cyc <= 0;
      exp_res <= '0;
    end else if (!busy) begin
      if (div_en_i) begin
        busy    <= 1'b1;
        cyc_cnt <= 1;
        exp_res <= model_result(operator_i == div_pkg::OP_REM, signed_mode_i, op_a_i, op_b_i);
        // Zero divisor finishes at once unless constant timing is asked for
        exp_cyc <= ((op_b_i == '0) && !data_ind_timing_i) ? 1 : 36;
      end
    end else if (valid_o) begin
      if (ready_i && div_en_i) begin
        busy <= 1'b0;
      end
    end else if (div_en_i) begin
      cyc_cnt <= cyc_cnt + 1;
    end
  end

  result_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(valid_o) |-> (result_o == exp_res))
    else begin
      fail_cnt++;
      $error("Fail result_o got %h expected %h", $sampled(result_o), $sampled(exp_res));
    end

  latency_matches: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(valid_o) |-> (cyc_cnt == exp_cyc))
    else begin
      fail_cnt++;
      $error("Fail valid_o latency got %h expected %h", $sampled(cyc_cnt), $sampled(exp_cyc));
    end

  result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> (valid_o && $stable(result_o)))
    else begin
      fail_cnt++;
      $error("valid_o or result_o changed while ready_i was low");
    end

  idle_after_reset: assert property (@(posedge clk_i) !rst_ni |=> !valid_o)
    else begin
      fail_cnt++;
      $error("valid_o was high right after reset");
    end

endmodule

bind div_unit div_unit_checker div_unit_checker_inst (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .div_en_i          (div_en_i),
  .operator_i        (operator_i),
  .signed_mode_i     (signed_mode_i),
  .op_a_i            (op_a_i),
  .op_b_i            (op_b_i),
  .data_ind_timing_i (data_ind_timing_i),
  .ready_i           (ready_i),
  .result_o          (result_o),
  .valid_o           (valid_o)
);

// File: tests/div_unit_tb.sv
// ####################################################################
// Testbench of the divider; the bound checker does the value checks
// Inputs change on the falling edge, operands come from a Galois LFSR
// ####################################################################

`timescale 1ns/1ps

module div_unit_tb;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       div_en_i;
  div_pkg::div_op_e           operator_i;
  logic [1:0]                 signed_mode_i;
  logic [div_pkg::DATA_W-1:0] op_a_i;
  logic [div_pkg::DATA_W-1:0] op_b_i;
  logic                       data_ind_timing_i;
  logic                       ready_i;
  logic [div_pkg::DATA_W-1:0] result_o;
  logic                       valid_o;

  logic [31:0] lfsr;
  int          timeouts;
  int          n_tests;
  int          n_failed;
  int          prev_errs;

  div_unit div_unit_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .div_en_i          (div_en_i),
    .operator_i        (operator_i),
    .signed_mode_i     (signed_mode_i),
    .op_a_i            (op_a_i),
    .op_b_i            (op_b_i),
    .data_ind_timing_i (data_ind_timing_i),
    .ready_i           (ready_i),
    .result_o          (result_o),
    .valid_o           (valid_o)
  );

  always #20 clk_i = ~clk_i;

  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic get_bits(input int n, output logic [31:0] val);
    int k;
    val = '0;
    for (k = 0; k < n; k++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic int error_total();
    return div_unit_inst.div_unit_checker_inst.fail_cnt + timeouts;
  endfunction

  // One division; stalls drop div_en_i for a few cycles, ready_wait delays the consumer
  task automatic run_div(input div_pkg::div_op_e op, input logic [1:0] mode,
                         input logic [31:0] a, input logic [31:0] b, input logic dit,
                         input int stalls, input int ready_wait);
    int cyc;
    int hold_cyc;
    @(negedge clk_i);
    operator_i        = op;
    signed_mode_i     = mode;
    op_a_i            = a;
    op_b_i            = b;
    data_ind_timing_i = dit;
    ready_i           = (ready_wait == 0);
    div_en_i          = 1'b1;
    cyc = 0;
    while (!valid_o && cyc < 100) begin
      @(negedge clk_i);
      cyc++;
      div_en_i = !(cyc >= 4 && cyc < 4 + stalls);
    end
    if (!valid_o) begin
      $display("Timeout: valid_o did not rise within 100 cycles (a %h, b %h)", a, b);
      timeouts++;
    end else begin
      hold_cyc = 0;
      while (hold_cyc < ready_wait) begin
        @(negedge clk_i);
        hold_cyc++;
      end
      ready_i = 1'b1;
      @(negedge clk_i);
    end
    div_en_i = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_total() - prev_errs;
    n_tests++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("Test %0d %s: %0d errors", n_tests, name, errs);
    end
    prev_errs = error_total();
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sh;
    int          i;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    div_en_i          = 1'b0;
    operator_i        = div_pkg::OP_DIV;
    signed_mode_i     = 2'b00;
    op_a_i            = '0;
    op_b_i            = '0;
    data_ind_timing_i = 1'b0;
    ready_i           = 1'b1;
    lfsr              = 32'd76755;
    timeouts          = 0;
    n_tests           = 0;
    n_failed          = 0;
    prev_errs         = 0;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    finish_test("reset state");

    // All four signed modes, both operators, divisors of varied size
    for (i = 0; i < 32; i++) begin
      get_bits(32, a);
      get_bits(32, b);
      get_bits(5, sh);
      // Arithmetic shift keeps negative divisors when B is signed
      if (i[1]) begin
        b = $signed(b) >>> sh;
      end else begin
        b = b >> sh;
      end
      run_div(div_pkg::div_op_e'(i[2]), i[1:0], a, b, i[3], 0, 0);
    end
    finish_test("random div and rem");

    get_bits(32, a);
    run_div(div_pkg::OP_DIV, 2'b11, a, '0, 1'b0, 0, 0);
    run_div(div_pkg::OP_REM, 2'b11, a, '0, 1'b0, 0, 0);
    run_div(div_pkg::OP_DIV, 2'b00, a, '0, 1'b0, 0, 0);
    finish_test("zero divisor, early finish");

    run_div(div_pkg::OP_DIV, 2'b11, a, '0, 1'b1, 0, 0);
    run_div(div_pkg::OP_REM, 2'b00, a, '0, 1'b1, 0, 0);
    finish_test("zero divisor, fixed timing");

    run_div(div_pkg::OP_DIV, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 0, 0);
    run_div(div_pkg::OP_REM, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 0, 0);
    finish_test("signed overflow");

    get_bits(32, a);
    get_bits(32, b);
    run_div(div_pkg::OP_DIV, 2'b11, a, b >> 7, 1'b0, 5, 0);
    run_div(div_pkg::OP_REM, 2'b00, a, b >> 3, 1'b0, 2, 0);
    finish_test("enable stalls");

    run_div(div_pkg::OP_DIV, 2'b00, a, b >> 4, 1'b0, 0, 4);
    run_div(div_pkg::OP_REM, 2'b11, a, '0, 1'b0, 0, 3);
    finish_test("result hold on back-pressure");

    $display("Tests: %0d, failed tests: %0d, assertion failures: %0d, timeouts: %0d",
             n_tests, n_failed, div_unit_inst.div_unit_checker_inst.fail_cnt, timeouts);
    if (error_total() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: files.f
logic/div_pkg.sv
logic/div_ctrl_fsm.sv
logic/div_bit_counter.sv
logic/div_datapath.sv
logic/div_unit.sv
tests/div_unit_checker.sv
tests/div_unit_tb.sv
